// File: logic/tcpcRegPkg.sv
`default_nettype none

package tcpcRegPkg;

	localparam int DATA_W       = 16; // host data bus
	localparam int BYTE_W       = 8;
	localparam int ADDR_W       = 8;
	localparam int TX_BUF_BYTES = 30; // header pair plus seven 4-byte objects

	typedef logic [DATA_W-1:0]               regDataT;
	typedef logic [BYTE_W-1:0]               regByteT;
	typedef logic [ADDR_W-1:0]               regAddrT;
	typedef logic [$clog2(TX_BUF_BYTES)-1:0] txIndexT;

	localparam regAddrT TX_BUF_BASE = 8'h52; // buffer spans 0x52..0x6F

	// identity and revision words
	localparam regAddrT ADDR_VENDOR_ID          = 8'h00;
	localparam regAddrT ADDR_PRODUCT_ID         = 8'h02;
	localparam regAddrT ADDR_DEVICE_ID          = 8'h04;
	localparam regAddrT ADDR_TYPEC_REV          = 8'h06;
	localparam regAddrT ADDR_PD_REV_VER         = 8'h08;
	localparam regAddrT ADDR_PD_IF_REV          = 8'h0A;
	// 16-bit control words
	localparam regAddrT ADDR_ALERT              = 8'h10;
	localparam regAddrT ADDR_ALERT_MASK         = 8'h12;
	localparam regAddrT ADDR_VBUS_SINK_DISC     = 8'h72;
	localparam regAddrT ADDR_VBUS_STOP_DISCH    = 8'h74;
	localparam regAddrT ADDR_VBUS_ALARM_HI      = 8'h76;
	localparam regAddrT ADDR_VBUS_ALARM_LO      = 8'h78;
	// byte-wide registers
	localparam regAddrT ADDR_POWER_STATUS_MASK  = 8'h14;
	localparam regAddrT ADDR_FAULT_STATUS_MASK  = 8'h15;
	localparam regAddrT ADDR_CONFIG_STD_OUTPUT  = 8'h18;
	localparam regAddrT ADDR_TCPC_CONTROL       = 8'h19;
	localparam regAddrT ADDR_ROLE_CONTROL       = 8'h1A;
	localparam regAddrT ADDR_FAULT_CONTROL      = 8'h1B;
	localparam regAddrT ADDR_POWER_CONTROL      = 8'h1C;
	localparam regAddrT ADDR_CC_STATUS          = 8'h1D;
	localparam regAddrT ADDR_POWER_STATUS       = 8'h1E;
	localparam regAddrT ADDR_FAULT_STATUS       = 8'h1F;
	localparam regAddrT ADDR_MSG_HEADER_INFO    = 8'h2E;
	localparam regAddrT ADDR_RECEIVE_DETECT     = 8'h2F;
	localparam regAddrT ADDR_TRANSMIT           = 8'h50;
	localparam regAddrT ADDR_TX_BYTE_COUNT      = 8'h51;

	localparam regDataT RST_ALERT               = 16'h0000;
	localparam regDataT RST_ALERT_MASK          = 16'h0FFF;
	localparam regDataT RST_VBUS_CFG            = 16'h0000; // all four threshold/alarm words
	localparam regByteT RST_POWER_STATUS_MASK   = 8'hFF;
	localparam regByteT RST_FAULT_STATUS_MASK   = 8'hFF;
	localparam regByteT RST_CONFIG_STD_OUTPUT   = 8'h60;
	localparam regByteT RST_TCPC_CONTROL        = 8'h00;
	localparam regByteT RST_ROLE_CONTROL        = 8'h0A;
	localparam regByteT RST_FAULT_CONTROL       = 8'h00;
	localparam regByteT RST_POWER_CONTROL       = 8'h60;
	localparam regByteT RST_FAULT_STATUS        = 8'h80;
	localparam regByteT RST_MSG_HEADER_INFO     = 8'h00;
	localparam regByteT RST_RECEIVE_DETECT      = 8'h00;
	localparam regByteT RST_TRANSMIT            = 8'h00;
	localparam regByteT RST_TX_BYTE_COUNT       = 8'h65;

	localparam regDataT TYPEC_REV  = 16'h0016;
	localparam regDataT PD_REV_VER = 16'h2012;
	localparam regDataT PD_IF_REV  = 16'h1012;

	typedef enum logic [4:0] {
		REG_VENDOR_ID, REG_PRODUCT_ID, REG_DEVICE_ID,
		REG_TYPEC_REV, REG_PD_REV_VER, REG_PD_IF_REV,
		REG_ALERT, REG_ALERT_MASK,
		REG_VBUS_SINK_DISC, REG_VBUS_STOP_DISCH, REG_VBUS_ALARM_HI, REG_VBUS_ALARM_LO,
		REG_POWER_STATUS_MASK, REG_FAULT_STATUS_MASK, REG_CONFIG_STD_OUTPUT,
		REG_TCPC_CONTROL, REG_ROLE_CONTROL, REG_FAULT_CONTROL, REG_POWER_CONTROL,
		REG_CC_STATUS, REG_POWER_STATUS, REG_FAULT_STATUS,
		REG_MSG_HEADER_INFO, REG_RECEIVE_DETECT, REG_TRANSMIT, REG_TX_BYTE_COUNT,
		REG_TXBUF, // any byte of the transmit buffer
		REG_NONE   // unmapped
	} regIdE;

endpackage

`default_nettype wire

// File: logic/tcpcAccessDecode.sv
`timescale 1ns/1ps
`default_nettype none

module tcpcAccessDecode import tcpcRegPkg::*;
(
	input  wire logic    req_i,
	input  wire logic    rnw_i,
	input  wire regAddrT addr_i,
	output regIdE        regId_o,
	output txIndexT      txIndex_o,
	output logic         rdEn_o,
	output logic         wrEn_o
);

	regAddrT bufOffset; // address relative to first buffer byte
	logic    mapped;

	always_comb
	begin
		bufOffset = addr_i - TX_BUF_BASE;
		txIndex_o = txIndexT'(bufOffset); // only meaningful for REG_TXBUF

		case (addr_i)
			ADDR_VENDOR_ID:         regId_o = REG_VENDOR_ID;
			ADDR_PRODUCT_ID:        regId_o = REG_PRODUCT_ID;
			ADDR_DEVICE_ID:         regId_o = REG_DEVICE_ID;
			ADDR_TYPEC_REV:         regId_o = REG_TYPEC_REV;
			ADDR_PD_REV_VER:        regId_o = REG_PD_REV_VER;
			ADDR_PD_IF_REV:         regId_o = REG_PD_IF_REV;
			ADDR_ALERT:             regId_o = REG_ALERT;
			ADDR_ALERT_MASK:        regId_o = REG_ALERT_MASK;
			ADDR_VBUS_SINK_DISC:    regId_o = REG_VBUS_SINK_DISC;
			ADDR_VBUS_STOP_DISCH:   regId_o = REG_VBUS_STOP_DISCH;
			ADDR_VBUS_ALARM_HI:     regId_o = REG_VBUS_ALARM_HI;
			ADDR_VBUS_ALARM_LO:     regId_o = REG_VBUS_ALARM_LO;
			ADDR_POWER_STATUS_MASK: regId_o = REG_POWER_STATUS_MASK;
			ADDR_FAULT_STATUS_MASK: regId_o = REG_FAULT_STATUS_MASK;
			ADDR_CONFIG_STD_OUTPUT: regId_o = REG_CONFIG_STD_OUTPUT;
			ADDR_TCPC_CONTROL:      regId_o = REG_TCPC_CONTROL;
			ADDR_ROLE_CONTROL:      regId_o = REG_ROLE_CONTROL;
			ADDR_FAULT_CONTROL:     regId_o = REG_FAULT_CONTROL;
			ADDR_POWER_CONTROL:     regId_o = REG_POWER_CONTROL;
			ADDR_CC_STATUS:         regId_o = REG_CC_STATUS;
			ADDR_POWER_STATUS:      regId_o = REG_POWER_STATUS;
			ADDR_FAULT_STATUS:      regId_o = REG_FAULT_STATUS;
			ADDR_MSG_HEADER_INFO:   regId_o = REG_MSG_HEADER_INFO;
			ADDR_RECEIVE_DETECT:    regId_o = REG_RECEIVE_DETECT;
			ADDR_TRANSMIT:          regId_o = REG_TRANSMIT;
			ADDR_TX_BYTE_COUNT:     regId_o = REG_TX_BYTE_COUNT;
			default:
			begin
				// 0x52..0x6F fall into the transmit buffer
				if (addr_i >= TX_BUF_BASE && bufOffset < TX_BUF_BYTES)
				begin
					regId_o = REG_TXBUF;
				end
				else
				begin
					regId_o = REG_NONE;
				end
			end
		endcase

		mapped = (regId_o != REG_NONE);
		rdEn_o = req_i && rnw_i && mapped;
		wrEn_o = req_i && !rnw_i && mapped; // unmapped access is dropped, no ack
	end

endmodule

`default_nettype wire

// File: logic/tcpcConfigBank.sv
`timescale 1ns/1ps
`default_nettype none

module tcpcConfigBank import tcpcRegPkg::*;
(
	input  wire logic    CLK,
	input  wire logic    reset,
	input  wire logic    wrEn_i,
	input  wire regIdE   regId_i,
	input  wire regDataT wrData_i,
	output regDataT      cfgRdData_o,
	output regByteT      roleControl_o,
	output regByteT      powerControl_o,
	output regByteT      transmit_o
);

	regDataT alert, alertMask;
	regDataT vbusSinkDisc, vbusStopDisch, vbusAlarmHi, vbusAlarmLo;
	regByteT powerStatusMask, faultStatusMask, configStdOutput, tcpcControl;
	regByteT roleControl, faultControl, powerControl, faultStatus;
	regByteT msgHeaderInfo, receiveDetect, transmit, txByteCount;
	regByteT wrByte;

	assign wrByte = wrData_i[BYTE_W-1:0]; // byte registers keep the low byte

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			alert           <= RST_ALERT;
			alertMask       <= RST_ALERT_MASK;
			vbusSinkDisc    <= RST_VBUS_CFG;
			vbusStopDisch   <= RST_VBUS_CFG;
			vbusAlarmHi     <= RST_VBUS_CFG;
			vbusAlarmLo     <= RST_VBUS_CFG;
			powerStatusMask <= RST_POWER_STATUS_MASK;
			faultStatusMask <= RST_FAULT_STATUS_MASK;
			configStdOutput <= RST_CONFIG_STD_OUTPUT;
			tcpcControl     <= RST_TCPC_CONTROL;
			roleControl     <= RST_ROLE_CONTROL;
			faultControl    <= RST_FAULT_CONTROL;
			powerControl    <= RST_POWER_CONTROL;
			faultStatus     <= RST_FAULT_STATUS;
			msgHeaderInfo   <= RST_MSG_HEADER_INFO;
			receiveDetect   <= RST_RECEIVE_DETECT;
			transmit        <= RST_TRANSMIT;
			txByteCount     <= RST_TX_BYTE_COUNT;
		end
		else if (wrEn_i)
		begin
			case (regId_i)
				REG_ALERT:             alert           <= wrData_i;
				REG_ALERT_MASK:        alertMask       <= wrData_i;
				REG_VBUS_SINK_DISC:    vbusSinkDisc    <= wrData_i;
				REG_VBUS_STOP_DISCH:   vbusStopDisch   <= wrData_i;
				REG_VBUS_ALARM_HI:     vbusAlarmHi     <= wrData_i;
				REG_VBUS_ALARM_LO:     vbusAlarmLo     <= wrData_i;
				REG_POWER_STATUS_MASK: powerStatusMask <= wrByte;
				REG_FAULT_STATUS_MASK: faultStatusMask <= wrByte;
				REG_CONFIG_STD_OUTPUT: configStdOutput <= wrByte;
				REG_TCPC_CONTROL:      tcpcControl     <= wrByte;
				REG_ROLE_CONTROL:      roleControl     <= wrByte;
				REG_FAULT_CONTROL:     faultControl    <= wrByte;
				REG_POWER_CONTROL:     powerControl    <= wrByte;
				REG_FAULT_STATUS:      faultStatus     <= wrByte;
				REG_MSG_HEADER_INFO:   msgHeaderInfo   <= wrByte;
				REG_RECEIVE_DETECT:    receiveDetect   <= wrByte;
				REG_TRANSMIT:          transmit        <= wrByte;
				REG_TX_BYTE_COUNT:     txByteCount     <= wrByte;
				default: ; // read-only ids and buffer bytes are handled elsewhere
			endcase
		end
	end

	always_comb
	begin
		case (regId_i)
			REG_ALERT:             cfgRdData_o = alert;
			REG_ALERT_MASK:        cfgRdData_o = alertMask;
			REG_VBUS_SINK_DISC:    cfgRdData_o = vbusSinkDisc;
			REG_VBUS_STOP_DISCH:   cfgRdData_o = vbusStopDisch;
			REG_VBUS_ALARM_HI:     cfgRdData_o = vbusAlarmHi;
			REG_VBUS_ALARM_LO:     cfgRdData_o = vbusAlarmLo;
			REG_POWER_STATUS_MASK: cfgRdData_o = regDataT'(powerStatusMask);
			REG_FAULT_STATUS_MASK: cfgRdData_o = regDataT'(faultStatusMask);
			REG_CONFIG_STD_OUTPUT: cfgRdData_o = regDataT'(configStdOutput);
			REG_TCPC_CONTROL:      cfgRdData_o = regDataT'(tcpcControl);
			REG_ROLE_CONTROL:      cfgRdData_o = regDataT'(roleControl);
			REG_FAULT_CONTROL:     cfgRdData_o = regDataT'(faultControl);
			REG_POWER_CONTROL:     cfgRdData_o = regDataT'(powerControl);
			REG_FAULT_STATUS:      cfgRdData_o = regDataT'(faultStatus);
			REG_MSG_HEADER_INFO:   cfgRdData_o = regDataT'(msgHeaderInfo);
			REG_RECEIVE_DETECT:    cfgRdData_o = regDataT'(receiveDetect);
			REG_TRANSMIT:          cfgRdData_o = regDataT'(transmit);
			REG_TX_BYTE_COUNT:     cfgRdData_o = regDataT'(txByteCount);
			default:               cfgRdData_o = '0;
		endcase
	end

	assign roleControl_o  = roleControl;
	assign powerControl_o = powerControl;
	assign transmit_o     = transmit;

	// role control leaves its reset value only through a host write
	roleHoldsUntilWrite: assert property (@(posedge CLK) disable iff (reset)
		(!$past(reset) && roleControl_o != $past(roleControl_o))
			|-> $past(wrEn_i && regId_i == REG_ROLE_CONTROL));

endmodule

`default_nettype wire

// File: logic/tcpcTxBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module tcpcTxBuffer import tcpcRegPkg::*;
(
	input  wire logic    CLK,
	input  wire logic    reset,
	input  wire logic    wrEn_i,
	input  wire regIdE   regId_i,
	input  wire txIndexT txIndex_i,
	input  wire regByteT wrByte_i,
	output regByteT      txRdByte_o
);

	regByteT txMem [TX_BUF_BYTES]; // header bytes first, then objects 1..7

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			for (int i = 0; i < TX_BUF_BYTES; i++)
			begin
				txMem[i] <= '0;
			end
		end
		else if (wrEn_i && regId_i == REG_TXBUF)
		begin
			txMem[txIndex_i] <= wrByte_i;
		end
	end

	// index 30 and 31 never address the buffer
	always_comb
	begin
		if (txIndex_i < TX_BUF_BYTES)
			txRdByte_o = txMem[txIndex_i];
		else
			txRdByte_o = '0;
	end

	// decoder must never hand over an index past the last buffer byte
	indexInRange: assert property (@(posedge CLK) disable iff (reset)
		(regId_i == REG_TXBUF) |-> (txIndex_i < TX_BUF_BYTES));

endmodule

`default_nettype wire

// File: logic/tcpcReadResponder.sv
`timescale 1ns/1ps
`default_nettype none

module tcpcReadResponder import tcpcRegPkg::*;
(
	input  wire logic    CLK,
	input  wire logic    reset,
	input  wire logic    rdEn_i,
	input  wire logic    wrEn_i,
	input  wire regIdE   regId_i,
	input  wire regDataT cfgRdData_i,
	input  wire regByteT txRdByte_i,
	input  wire regDataT vendorId_i,
	input  wire regDataT productId_i,
	input  wire regDataT deviceId_i,
	input  wire regByteT ccStatus_i,
	input  wire regByteT powerStatus_i,
	output logic         ack_o,
	output regDataT      rdData_o
);

	regDataT rdWord; // read source picked by register id

	always_comb
	begin
		case (regId_i)
			REG_VENDOR_ID:    rdWord = vendorId_i; // straps, no storage
			REG_PRODUCT_ID:   rdWord = productId_i;
			REG_DEVICE_ID:    rdWord = deviceId_i;
			REG_TYPEC_REV:    rdWord = TYPEC_REV;
			REG_PD_REV_VER:   rdWord = PD_REV_VER;
			REG_PD_IF_REV:    rdWord = PD_IF_REV;
			REG_CC_STATUS:    rdWord = regDataT'(ccStatus_i); // live value at the edge
			REG_POWER_STATUS: rdWord = regDataT'(powerStatus_i);
			REG_TXBUF:        rdWord = regDataT'(txRdByte_i);
			default:          rdWord = cfgRdData_i; // bank registers
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			ack_o    <= 1'b0;
			rdData_o <= '0;
		end
		else
		begin
			ack_o    <= rdEn_i || wrEn_i; // writes are acked too, read-only or not
			rdData_o <= rdEn_i ? rdWord : '0;
		end
	end

	// an ack always traces back to a mapped address one cycle earlier
	ackOnlyMapped: assert property (@(posedge CLK) disable iff (reset)
		ack_o |-> $past(regId_i != REG_NONE));

endmodule

`default_nettype wire

// File: logic/tcpcRegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module tcpcRegisterFile import tcpcRegPkg::*;
(
	input  wire logic    CLK,
	input  wire logic    reset,
	input  wire logic    req_i,
	input  wire logic    rnw_i,
	input  wire regAddrT addr_i,
	input  wire regDataT wrData_i,
	input  wire regDataT vendorId_i,
	input  wire regDataT productId_i,
	input  wire regDataT deviceId_i,
	input  wire regByteT ccStatus_i,
	input  wire regByteT powerStatus_i,
	output logic         ack_o,
	output regDataT      rdData_o,
	output regByteT      roleControl_o,
	output regByteT      powerControl_o,
	output regByteT      transmit_o
);

	regIdE   regId;
	txIndexT txIndex;
	logic    rdEn;
	logic    wrEn;
	regDataT cfgRdData;
	regByteT txRdByte;

	tcpcAccessDecode u_decode (
		.req_i     (req_i),
		.rnw_i     (rnw_i),
		.addr_i    (addr_i),
		.regId_o   (regId),
		.txIndex_o (txIndex),
		.rdEn_o    (rdEn),
		.wrEn_o    (wrEn)
	);

	tcpcConfigBank u_configBank (
		.CLK            (CLK),
		.reset          (reset),
		.wrEn_i         (wrEn),
		.regId_i        (regId),
		.wrData_i       (wrData_i),
		.cfgRdData_o    (cfgRdData),
		.roleControl_o  (roleControl_o),
		.powerControl_o (powerControl_o),
		.transmit_o     (transmit_o)
	);

	tcpcTxBuffer u_txBuffer (
		.CLK        (CLK),
		.reset      (reset),
		.wrEn_i     (wrEn),
		.regId_i    (regId),
		.txIndex_i  (txIndex),
		.wrByte_i   (wrData_i[BYTE_W-1:0]), // buffer bytes take the low byte
		.txRdByte_o (txRdByte)
	);

	tcpcReadResponder u_responder (
		.CLK           (CLK),
		.reset         (reset),
		.rdEn_i        (rdEn),
		.wrEn_i        (wrEn),
		.regId_i       (regId),
		.cfgRdData_i   (cfgRdData),
		.txRdByte_i    (txRdByte),
		.vendorId_i    (vendorId_i),
		.productId_i   (productId_i),
		.deviceId_i    (deviceId_i),
		.ccStatus_i    (ccStatus_i),
		.powerStatus_i (powerStatus_i),
		.ack_o         (ack_o),
		.rdData_o      (rdData_o)
	);

endmodule

`default_nettype wire

// File: verification/tcpcRegFileTb.sv
`timescale 1ns/1ps
`default_nettype none

module tcpcRegFileTb import tcpcRegPkg::*;
();

	localparam int CLK_PERIOD      = 100;
	localparam int DRIVE_DELAY     = 10;
	localparam int RESET_CYCLES    = 16;
	localparam int ACCESS_COUNT    = 48 + 18 + 36 + 60 + 6 + 28; // one cycle per access
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + ACCESS_COUNT + 100;

	localparam regDataT VENDOR_STRAP  = 16'h3A51;
	localparam regDataT PRODUCT_STRAP = 16'h7C02;
	localparam regDataT DEVICE_STRAP  = 16'h0104;

	localparam regAddrT WORD_ADDRS [6] = '{ADDR_ALERT, ADDR_ALERT_MASK, ADDR_VBUS_SINK_DISC,
		ADDR_VBUS_STOP_DISCH, ADDR_VBUS_ALARM_HI, ADDR_VBUS_ALARM_LO};
	localparam regAddrT BYTE_ADDRS [12] = '{ADDR_POWER_STATUS_MASK, ADDR_FAULT_STATUS_MASK,
		ADDR_CONFIG_STD_OUTPUT, ADDR_TCPC_CONTROL, ADDR_ROLE_CONTROL, ADDR_FAULT_CONTROL,
		ADDR_POWER_CONTROL, ADDR_FAULT_STATUS, ADDR_MSG_HEADER_INFO, ADDR_RECEIVE_DETECT,
		ADDR_TRANSMIT, ADDR_TX_BYTE_COUNT};
	localparam regAddrT ID_ADDRS [6] = '{ADDR_VENDOR_ID, ADDR_PRODUCT_ID, ADDR_DEVICE_ID,
		ADDR_TYPEC_REV, ADDR_PD_REV_VER, ADDR_PD_IF_REV};
	localparam regDataT ID_VALUES [6] = '{VENDOR_STRAP, PRODUCT_STRAP, DEVICE_STRAP,
		TYPEC_REV, PD_REV_VER, PD_IF_REV};

	logic    CLK, reset, req_i, rnw_i, ack_o;
	regAddrT addr_i;
	regDataT wrData_i, vendorId_i, productId_i, deviceId_i, rdData_o;
	regByteT ccStatus_i, powerStatus_i, roleControl_o, powerControl_o, transmit_o;

	regDataT shadow [256]; // expected content, indexed by address

	tcpcRegisterFile u_dut (
		.CLK            (CLK),
		.reset          (reset),
		.req_i          (req_i),
		.rnw_i          (rnw_i),
		.addr_i         (addr_i),
		.wrData_i       (wrData_i),
		.vendorId_i     (vendorId_i),
		.productId_i    (productId_i),
		.deviceId_i     (deviceId_i),
		.ccStatus_i     (ccStatus_i),
		.powerStatus_i  (powerStatus_i),
		.ack_o          (ack_o),
		.rdData_o       (rdData_o),
		.roleControl_o  (roleControl_o),
		.powerControl_o (powerControl_o),
		.transmit_o     (transmit_o)
	);

	initial
	begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("=== FAIL ===");
		$fatal(1, "simulation timed out");
	end

	task automatic compareWord(input string name, input regDataT expected, input regDataT actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s expected 0x%04h actual 0x%04h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic compareByte(input string name, input regByteT expected, input regByteT actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s expected 0x%02h actual 0x%02h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "byte mismatch");
		end
	endtask

	// one edge later, response is registered and stable
	task automatic advanceCycle();
		@(posedge CLK);
		#DRIVE_DELAY;
	endtask

	// response after a cycle with no accepted access
	task automatic checkIdleResponse();
		if (ack_o !== 1'b0)
		begin
			$display("acknowledge was present after a cycle without an accepted access");
			$display("=== FAIL ===");
			$fatal(1, "unexpected acknowledge");
		end
		compareWord("rdData_o idle", '0, rdData_o);
	endtask

	task automatic busAccess(input logic rnw, input regAddrT addr, input regDataT data,
		input logic ackExpected);
		req_i    = 1'b1;
		rnw_i    = rnw;
		addr_i   = addr;
		wrData_i = data;
		advanceCycle();
		req_i = 1'b0;
		if (ack_o !== ackExpected)
		begin
			$display("access to address 0x%02h: acknowledge was %b, expected %b", addr, ack_o,
				ackExpected);
			$display("=== FAIL ===");
			$fatal(1, "acknowledge mismatch");
		end
	endtask

	task automatic busWrite(input regAddrT addr, input regDataT data);
		busAccess(1'b0, addr, data, 1'b1);
		compareWord("rdData_o after write", '0, rdData_o); // writes return no data
	endtask

	task automatic busRead(input regAddrT addr, output regDataT data);
		busAccess(1'b1, addr, '0, 1'b1);
		data = rdData_o;
	endtask

	task automatic readAndCompare(input regAddrT addr, input regDataT expected);
		regDataT data;
		busRead(addr, data);
		compareWord($sformatf("rdData_o@0x%02h", addr), expected, data);
	endtask

	task automatic loadResetShadow();
		foreach (shadow[i])
			shadow[i] = '0;
		shadow[ADDR_ALERT_MASK]        = RST_ALERT_MASK;
		shadow[ADDR_POWER_STATUS_MASK] = 16'h00FF;
		shadow[ADDR_FAULT_STATUS_MASK] = 16'h00FF;
		shadow[ADDR_CONFIG_STD_OUTPUT] = 16'h0060;
		shadow[ADDR_ROLE_CONTROL]      = 16'h000A;
		shadow[ADDR_POWER_CONTROL]     = 16'h0060;
		shadow[ADDR_FAULT_STATUS]      = 16'h0080;
		shadow[ADDR_TX_BYTE_COUNT]     = 16'h0065;
	endtask

	task automatic checkControlReadback(); // every writable register against the model
		foreach (WORD_ADDRS[i])
			readAndCompare(WORD_ADDRS[i], shadow[WORD_ADDRS[i]]);
		foreach (BYTE_ADDRS[i])
			readAndCompare(BYTE_ADDRS[i], shadow[BYTE_ADDRS[i]]);
	endtask

	task automatic checkResetValues();
		checkIdleResponse();
		checkControlReadback();
		for (int i = 0; i < TX_BUF_BYTES; i++)
			readAndCompare(regAddrT'(TX_BUF_BASE + i), '0);
		compareByte("roleControl_o", 8'h0A, roleControl_o);
		compareByte("powerControl_o", 8'h60, powerControl_o);
		compareByte("transmit_o", 8'h00, transmit_o);
	endtask

	task automatic checkIdentity();
		foreach (ID_ADDRS[i])
			readAndCompare(ID_ADDRS[i], ID_VALUES[i]);
		foreach (ID_ADDRS[i])
			busWrite(ID_ADDRS[i], ~ID_VALUES[i]); // acked but ignored
		foreach (ID_ADDRS[i])
			readAndCompare(ID_ADDRS[i], ID_VALUES[i]);
	endtask

	task automatic checkControlRegs();
		regDataT value;
		foreach (WORD_ADDRS[i])
		begin
			value = regDataT'($urandom());
			busWrite(WORD_ADDRS[i], value);
			shadow[WORD_ADDRS[i]] = value;
			readAndCompare(WORD_ADDRS[i], value); // back to back with the write
		end
		foreach (BYTE_ADDRS[i])
		begin
			value = regDataT'($urandom());
			busWrite(BYTE_ADDRS[i], value);
			shadow[BYTE_ADDRS[i]] = {8'h00, value[7:0]}; // upper byte dropped
			readAndCompare(BYTE_ADDRS[i], shadow[BYTE_ADDRS[i]]);
		end
		compareByte("roleControl_o", shadow[ADDR_ROLE_CONTROL][7:0], roleControl_o);
		compareByte("powerControl_o", shadow[ADDR_POWER_CONTROL][7:0], powerControl_o);
		compareByte("transmit_o", shadow[ADDR_TRANSMIT][7:0], transmit_o);
	endtask

	task automatic checkTxBuffer();
		regByteT written [TX_BUF_BYTES];
		for (int i = 0; i < TX_BUF_BYTES; i++)
		begin
			written[i] = regByteT'($urandom());
			busWrite(regAddrT'(TX_BUF_BASE + i), {8'hC3, written[i]});
		end
		for (int i = 0; i < TX_BUF_BYTES; i++)
			readAndCompare(regAddrT'(TX_BUF_BASE + i), {8'h00, written[i]});
	endtask

	task automatic checkStatus();
		regDataT value;
		ccStatus_i    = regByteT'($urandom());
		powerStatus_i = regByteT'($urandom());
		readAndCompare(ADDR_CC_STATUS, {8'h00, ccStatus_i});
		readAndCompare(ADDR_POWER_STATUS, {8'h00, powerStatus_i});
		ccStatus_i    = ~ccStatus_i; // live inputs, no storage
		powerStatus_i = powerStatus_i ^ 8'h5A;
		readAndCompare(ADDR_CC_STATUS, {8'h00, ccStatus_i});
		readAndCompare(ADDR_POWER_STATUS, {8'h00, powerStatus_i});
		value = regDataT'($urandom());
		busWrite(ADDR_FAULT_STATUS, value);
		shadow[ADDR_FAULT_STATUS] = {8'h00, value[7:0]};
		readAndCompare(ADDR_FAULT_STATUS, shadow[ADDR_FAULT_STATUS]);
	endtask

	task automatic checkIdleAndUnmapped();
		req_i = 1'b0;
		repeat (4)
		begin
			advanceCycle(); // idle cycle
			checkIdleResponse();
			busAccess(1'b0, 8'h20, 16'hFFFF, 1'b0); // unmapped write mixed with idle
			compareWord("rdData_o unmapped write", '0, rdData_o);
		end
		busAccess(1'b1, 8'h20, '0, 1'b0);
		compareWord("rdData_o unmapped", '0, rdData_o);
		busAccess(1'b0, 8'h70, 16'h1234, 1'b0); // first byte past the buffer
		checkControlReadback();
	endtask

	initial
	begin
		void'($urandom(32'he4d05bdf));
		reset         = 1'b1;
		req_i         = 1'b0;
		rnw_i         = 1'b0;
		addr_i        = '0;
		wrData_i      = '0;
		vendorId_i    = VENDOR_STRAP;
		productId_i   = PRODUCT_STRAP;
		deviceId_i    = DEVICE_STRAP;
		ccStatus_i    = '0;
		powerStatus_i = '0;
		loadResetShadow();
		repeat (RESET_CYCLES) @(posedge CLK);
		#DRIVE_DELAY;
		reset = 1'b0;
		checkResetValues();
		checkIdentity();
		checkControlRegs();
		checkTxBuffer();
		checkStatus();
		checkIdleAndUnmapped();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
logic/tcpcRegPkg.sv
logic/tcpcAccessDecode.sv
logic/tcpcConfigBank.sv
logic/tcpcTxBuffer.sv
logic/tcpcReadResponder.sv
logic/tcpcRegisterFile.sv
verification/tcpcRegFileTb.sv

// File: Makefile
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: obj_dir/VtcpcRegFileTb

obj_dir/VtcpcRegFileTb: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tcpcRegFileTb \
		-Mdir obj_dir -f vlog.f

run: obj_dir/VtcpcRegFileTb
	./obj_dir/VtcpcRegFileTb

clean:
	rm -rf obj_dir
